// File: hdl/icache_pkg.sv
//////////////////////////////////////////////////////////////////////
// geometry and types of the direct-mapped instruction cache
// 32-bit byte addresses, four 32-bit words per line, fixed here
// index width is a module parameter, tag width follows from it
// byte offset bits 1:0 are ignored by the cache
//////////////////////////////////////////////////////////////////////

package icache_pkg;

    localparam int ADDR_W         = 32;                   // cpu byte address
    localparam int WORD_W         = 32;                   // one instruction
    localparam int WORDS_PER_LINE = 4;
    localparam int OFFSET_W       = 2;                    // word offset, addr[3:2]
    localparam int LINE_ADDR_LSB  = 4;                    // first bit above the line
    localparam int LINE_W         = WORDS_PER_LINE * WORD_W;
    localparam int LINE_ADDR_W    = ADDR_W - LINE_ADDR_LSB; // tag + index, 28 bits

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [LINE_W-1:0] line_t;                    // word 0 in bits 31:0

    // cpu side request sequencing
    typedef enum logic [1:0] {
        CTRL_IDLE    = 2'd0,                              // waiting for cyc/stb
        CTRL_LOOKUP  = 2'd1,                              // array outputs valid, tag compare
        CTRL_REFILL  = 2'd2,                              // miss, refill engine busy
        CTRL_RESPOND = 2'd3                               // ack to cpu
    } ctrl_state_e;

    // memory side line fetch
    typedef enum logic [1:0] {
        RF_IDLE = 2'd0,
        RF_BEAT = 2'd1,                                   // cyc/stb up until ack
        RF_DONE = 2'd2                                    // line assembled, done pulse
    } refill_state_e;

endpackage

// File: hdl/wb_pkg.sv
//////////////////////////////////////////////////////////////////////
// wishbone classic signal bundles, 32-bit address and data
// read-only use: we is carried but always driven low
// no sel, err, rty or burst tags
//////////////////////////////////////////////////////////////////////

package wb_pkg;

    localparam int WB_ADR_W = 32;
    localparam int WB_DAT_W = 32;

    // master to slave, 35 bits
    typedef struct packed {
        logic                cyc;                         // bus cycle in progress
        logic                stb;                         // valid transfer
        logic                we;                          // write enable
        logic [WB_ADR_W-1:0] adr;                         // byte address
    } wb_req_t;

    // slave to master, 33 bits
    typedef struct packed {
        logic                ack;                         // one cycle per transfer
        logic [WB_DAT_W-1:0] dat;                         // read data
    } wb_rsp_t;

endpackage

// File: hdl/icache_arrays.sv
//////////////////////////////////////////////////////////////////////
// valid bits, tag store and line store, 2^INDEX_W entries
// reads are registered, one cycle, old data on same-index write
// flush and reset clear only the valid bits, flush beats a write
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module icache_arrays #(
    parameter int INDEX_W = 8
) (
    input  logic                                       rst,      // clock
    input  logic                                       rst_n,
    input  logic                                       flush,
    input  logic [INDEX_W-1:0]                         rd_index,
    output logic                                       rd_valid,
    output logic [icache_pkg::LINE_ADDR_W-INDEX_W-1:0] rd_tag,
    output icache_pkg::line_t                          rd_line,
    input  logic                                       wr_en,
    input  logic [INDEX_W-1:0]                         wr_index,
    input  logic [icache_pkg::LINE_ADDR_W-INDEX_W-1:0] wr_tag,
    input  icache_pkg::line_t                          wr_line
);

    localparam int TAG_W = icache_pkg::LINE_ADDR_W - INDEX_W;
    localparam int LINES = 1 << INDEX_W;

    logic [LINES-1:0]  valid_q;                           // one flop per line
    logic [TAG_W-1:0]  tag_mem  [LINES];
    icache_pkg::line_t line_mem [LINES];

    always_ff @(posedge rst or negedge rst_n) begin
        if (!rst_n) begin
            valid_q  <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (flush) begin
                valid_q <= '0;                            // all lines at once
            end else if (wr_en) begin
                valid_q[wr_index] <= 1'b1;
            end
            rd_valid <= valid_q[rd_index];                // pre-edge value
        end
    end

    always_ff @(posedge rst) begin
        if (wr_en) begin
            tag_mem[wr_index]  <= wr_tag;
            line_mem[wr_index] <= wr_line;
        end
        rd_tag  <= tag_mem[rd_index];
        rd_line <= line_mem[rd_index];
    end

    // a refill write must land on a real line
    a_wr_index_known: assert property (@(posedge rst) disable iff (!rst_n)
        wr_en |-> !$isunknown(wr_index));

endmodule

// File: hdl/icache_ctrl.sv
//////////////////////////////////////////////////////////////////////
// cpu side wishbone classic read slave of the icache
// a hit acks two cycles after stb is sampled
// a miss acks one cycle after the refilled line is written
// one request at a time and the cpu cannot stall the ack
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module icache_ctrl #(
    parameter int INDEX_W = 8
) (
    input  logic                                       rst,      // clock
    input  logic                                       rst_n,
    input  wb_pkg::wb_req_t                            cpu_req,
    output wb_pkg::wb_rsp_t                            cpu_rsp,
    output logic [INDEX_W-1:0]                         rd_index,
    input  logic                                       rd_valid,
    input  logic [icache_pkg::LINE_ADDR_W-INDEX_W-1:0] rd_tag,
    input  icache_pkg::line_t                          rd_line,
    output logic                                       wr_en,
    output logic [INDEX_W-1:0]                         wr_index,
    output logic [icache_pkg::LINE_ADDR_W-INDEX_W-1:0] wr_tag,
    output icache_pkg::line_t                          wr_line,
    output logic                                       refill_start,
    output logic [icache_pkg::LINE_ADDR_W-1:0]         refill_line_addr,
    input  logic                                       refill_done,
    input  icache_pkg::line_t                          refill_line
);

    localparam int TAG_W   = icache_pkg::LINE_ADDR_W - INDEX_W;
    localparam int IDX_LSB = icache_pkg::LINE_ADDR_LSB;
    localparam int OFF_LSB = icache_pkg::LINE_ADDR_LSB - icache_pkg::OFFSET_W;

    icache_pkg::ctrl_state_e           state;
    icache_pkg::ctrl_state_e           state_nxt;
    icache_pkg::addr_t                 req_addr;          // latched on accept
    icache_pkg::word_t                 rsp_dat;           // word for the ack cycle
    logic [TAG_W-1:0]                  req_tag;
    logic [INDEX_W-1:0]                req_index;
    logic [icache_pkg::OFFSET_W-1:0]   req_off;
    logic                              cpu_valid;
    logic                              hit;

    // pick one word out of a line
    function automatic icache_pkg::word_t word_sel(
        input icache_pkg::line_t               line,
        input logic [icache_pkg::OFFSET_W-1:0] off
    );
        return line[off*icache_pkg::WORD_W +: icache_pkg::WORD_W];
    endfunction

    assign cpu_valid = cpu_req.cyc & cpu_req.stb;

    assign req_tag   = req_addr[icache_pkg::ADDR_W-1 -: TAG_W];
    assign req_index = req_addr[IDX_LSB +: INDEX_W];
    assign req_off   = req_addr[OFF_LSB +: icache_pkg::OFFSET_W];

    // index straight off the bus in IDLE so the arrays answer in LOOKUP
    assign rd_index = (state == icache_pkg::CTRL_IDLE) ?
                      cpu_req.adr[IDX_LSB +: INDEX_W] : req_index;

    assign hit = rd_valid && (rd_tag == req_tag);        // hit_read

    always_comb begin
        state_nxt = state;
        case (state)
            icache_pkg::CTRL_IDLE: begin
                if (cpu_valid) begin
                    state_nxt = icache_pkg::CTRL_LOOKUP;
                end
            end
            icache_pkg::CTRL_LOOKUP: begin
                state_nxt = hit ? icache_pkg::CTRL_RESPOND : icache_pkg::CTRL_REFILL;
            end
            icache_pkg::CTRL_REFILL: begin
                if (refill_done) begin
                    state_nxt = icache_pkg::CTRL_RESPOND;
                end
            end
            icache_pkg::CTRL_RESPOND: begin
                state_nxt = icache_pkg::CTRL_IDLE;       // single ack cycle
            end
            default: state_nxt = icache_pkg::CTRL_IDLE;
        endcase
    end

    always_ff @(posedge rst or negedge rst_n) begin
        if (!rst_n) begin
            state <= icache_pkg::CTRL_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge rst) begin
        if (state == icache_pkg::CTRL_IDLE && cpu_valid) begin
            req_addr <= cpu_req.adr;
        end
        if (state == icache_pkg::CTRL_LOOKUP && hit) begin
            rsp_dat <= word_sel(rd_line, req_off);
        end else if (state == icache_pkg::CTRL_REFILL && refill_done) begin
            rsp_dat <= word_sel(refill_line, req_off);   // forward from new line
        end
    end

    // one-cycle refill request in LOOKUP on a miss
    assign refill_start     = (state == icache_pkg::CTRL_LOOKUP) && !hit;
    assign refill_line_addr = req_addr[icache_pkg::ADDR_W-1:IDX_LSB];

    // line write in the refill_done cycle
    assign wr_en    = (state == icache_pkg::CTRL_REFILL) && refill_done;
    assign wr_index = req_index;
    assign wr_tag   = req_tag;
    assign wr_line  = refill_line;

    assign cpu_rsp.ack = (state == icache_pkg::CTRL_RESPOND);
    assign cpu_rsp.dat = rsp_dat;

    // cpu keeps its read request up until the ack
    a_ack_in_req: assert property (@(posedge rst) disable iff (!rst_n)
        cpu_rsp.ack |-> cpu_valid && !cpu_req.we);

    // refill engine idle when a new line is requested
    a_start_refill_idle: assert property (@(posedge rst) disable iff (!rst_n)
        refill_start |-> !refill_done);

endmodule

// File: hdl/icache_refill.sv
//////////////////////////////////////////////////////////////////////
// wishbone classic read master fetching one cache line
// four single reads at line base + 0, 4, 8 and 12 with cyc held throughout
// no timeout as the memory may hold off ack for as long as it likes
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module icache_refill (
    input  logic                               rst,      // clock
    input  logic                               rst_n,
    input  logic                               refill_start,
    input  logic [icache_pkg::LINE_ADDR_W-1:0] refill_line_addr,
    output logic                               refill_done,
    output icache_pkg::line_t                  refill_line,
    output wb_pkg::wb_req_t                    mem_req,
    input  wb_pkg::wb_rsp_t                    mem_rsp
);

    localparam int BYTE_W = icache_pkg::LINE_ADDR_LSB - icache_pkg::OFFSET_W;

    icache_pkg::refill_state_e          state;
    icache_pkg::refill_state_e          state_nxt;
    logic [icache_pkg::OFFSET_W-1:0]    beat;             // word slot in flight
    logic [icache_pkg::LINE_ADDR_W-1:0] base;             // line address of this refill
    logic                               beat_ack;

    assign beat_ack = (state == icache_pkg::RF_BEAT) && mem_rsp.ack;

    always_comb begin
        state_nxt = state;
        case (state)
            icache_pkg::RF_IDLE: begin
                if (refill_start) begin
                    state_nxt = icache_pkg::RF_BEAT;
                end
            end
            icache_pkg::RF_BEAT: begin
                if (beat_ack && beat == '1) begin
                    state_nxt = icache_pkg::RF_DONE;     // fourth word in
                end
            end
            icache_pkg::RF_DONE: state_nxt = icache_pkg::RF_IDLE;
            default:             state_nxt = icache_pkg::RF_IDLE;
        endcase
    end

    always_ff @(posedge rst or negedge rst_n) begin
        if (!rst_n) begin
            state <= icache_pkg::RF_IDLE;
            beat  <= '0;
        end else begin
            state <= state_nxt;
            if (beat_ack) begin
                beat <= beat + 1'b1;                      // wraps to 0 after last beat
            end
        end
    end

    always_ff @(posedge rst) begin
        if (state == icache_pkg::RF_IDLE && refill_start) begin
            base <= refill_line_addr;
        end
        if (beat_ack) begin
            refill_line[beat*icache_pkg::WORD_W +: icache_pkg::WORD_W] <= mem_rsp.dat;
        end
    end

    assign mem_req.cyc = (state == icache_pkg::RF_BEAT);
    assign mem_req.stb = (state == icache_pkg::RF_BEAT);  // next beat right after ack
    assign mem_req.we  = 1'b0;
    assign mem_req.adr = {base, beat, {BYTE_W{1'b0}}};

    assign refill_done = (state == icache_pkg::RF_DONE);

    // the memory acks only a beat in flight
    a_ack_in_beat: assert property (@(posedge rst) disable iff (!rst_n)
        mem_rsp.ack |-> mem_req.cyc && mem_req.stb);

    // address held until the memory acks the beat
    a_adr_held: assert property (@(posedge rst) disable iff (!rst_n)
        mem_req.stb && !mem_rsp.ack |=> mem_req.stb && $stable(mem_req.adr));

endmodule

// File: hdl/icache_top.sv
//////////////////////////////////////////////////////////////////////
// direct-mapped instruction cache, 2^INDEX_W lines of 16 bytes
// cpu port and memory port are wishbone classic, reads only
// flush is a one-cycle pulse, a refill in flight still completes
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module icache_top #(
    parameter int INDEX_W = 8                             // 256 lines
) (
    input  logic            rst,                          // clock
    input  logic            rst_n,
    input  logic            flush,
    input  wb_pkg::wb_req_t cpu_req,
    output wb_pkg::wb_rsp_t cpu_rsp,
    output wb_pkg::wb_req_t mem_req,
    input  wb_pkg::wb_rsp_t mem_rsp
);

    localparam int TAG_W = icache_pkg::LINE_ADDR_W - INDEX_W;

    logic [INDEX_W-1:0]                 rd_index;
    logic                               rd_valid;
    logic [TAG_W-1:0]                   rd_tag;
    icache_pkg::line_t                  rd_line;
    logic                               wr_en;
    logic [INDEX_W-1:0]                 wr_index;
    logic [TAG_W-1:0]                   wr_tag;
    icache_pkg::line_t                  wr_line;
    logic                               refill_start;
    logic [icache_pkg::LINE_ADDR_W-1:0] refill_line_addr;
    logic                               refill_done;
    icache_pkg::line_t                  refill_line;

    icache_ctrl #(
        .INDEX_W (INDEX_W)
    ) u_ctrl (
        .rst              (rst),
        .rst_n            (rst_n),
        .cpu_req          (cpu_req),
        .cpu_rsp          (cpu_rsp),
        .rd_index         (rd_index),
        .rd_valid         (rd_valid),
        .rd_tag           (rd_tag),
        .rd_line          (rd_line),
        .wr_en            (wr_en),
        .wr_index         (wr_index),
        .wr_tag           (wr_tag),
        .wr_line          (wr_line),
        .refill_start     (refill_start),
        .refill_line_addr (refill_line_addr),
        .refill_done      (refill_done),
        .refill_line      (refill_line)
    );

    icache_arrays #(
        .INDEX_W (INDEX_W)
    ) u_arrays (
        .rst      (rst),
        .rst_n    (rst_n),
        .flush    (flush),
        .rd_index (rd_index),
        .rd_valid (rd_valid),
        .rd_tag   (rd_tag),
        .rd_line  (rd_line),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_tag   (wr_tag),
        .wr_line  (wr_line)
    );

    icache_refill u_refill (
        .rst              (rst),
        .rst_n            (rst_n),
        .refill_start     (refill_start),
        .refill_line_addr (refill_line_addr),
        .refill_done      (refill_done),
        .refill_line      (refill_line),
        .mem_req          (mem_req),
        .mem_rsp          (mem_rsp)
    );

endmodule

// File: sim/wb_mem_model.sv
//////////////////////////////////////////////////////////////////////
// wishbone classic read slave for the icache memory port
// data at byte address A is A ^ 32'h5a5a_0000, writes are ignored
// each beat is acked after 1 to 4 edges, $random with a fixed seed
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module wb_mem_model (
    input  logic            rst,                          // clock
    input  logic            rst_n,
    input  wb_pkg::wb_req_t mem_req,
    output wb_pkg::wb_rsp_t mem_rsp
);

    int         seed = 32'hc8c0;                          // ack delay stream
    logic       busy;                                     // beat seen, ack pending
    logic [1:0] wait_cnt;                                 // extra cycles before ack

    function automatic icache_pkg::word_t mem_word(input icache_pkg::addr_t adr);
        return adr ^ 32'h5a5a_0000;
    endfunction

    always @(posedge rst or negedge rst_n) begin
        if (!rst_n) begin
            mem_rsp  <= '0;
            busy     <= 1'b0;
            wait_cnt <= 2'd0;
        end else begin
            mem_rsp.ack <= 1'b0;                          // ack lasts one cycle
            if (mem_req.cyc && mem_req.stb && !mem_rsp.ack) begin
                if (!busy) begin
                    busy     <= 1'b1;                     // new beat, draw a delay
                    wait_cnt <= 2'($random(seed));
                end else if (wait_cnt == 2'd0) begin
                    busy        <= 1'b0;
                    mem_rsp.ack <= 1'b1;
                    mem_rsp.dat <= mem_word(mem_req.adr);
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end
        end
    end

endmodule

// File: sim/tb_icache.sv
//////////////////////////////////////////////////////////////////////
// directed and random fetch tests for the icache, INDEX_W 8
// cpu side acts as a wishbone classic master, one fetch at a time
// expected data follows the memory model pattern A ^ 32'h5a5a_0000
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_icache;

    localparam int INDEX_W       = 8;
    localparam int LINES         = 1 << INDEX_W;
    localparam int TAG_W         = icache_pkg::LINE_ADDR_W - INDEX_W;
    localparam int FETCH_TIMEOUT = 200;                   // edges per fetch

    logic                 rst;                            // clock
    logic                 rst_n;
    logic                 flush;
    wb_pkg::wb_req_t      cpu_req;
    wb_pkg::wb_rsp_t      cpu_rsp;
    wb_pkg::wb_req_t      mem_req;
    wb_pkg::wb_rsp_t      mem_rsp;
    wb_pkg::wb_req_t      beat_q[$];                      // acked memory beats
    int                   seed = 32'hc8c0;
    logic [LINES-1:0]     model_valid;                    // reference tag model
    logic [TAG_W-1:0]     model_tag [LINES];

    icache_top #(.INDEX_W(INDEX_W)) UUT (
        .rst(rst), .rst_n(rst_n), .flush(flush), .cpu_req(cpu_req),
        .cpu_rsp(cpu_rsp), .mem_req(mem_req), .mem_rsp(mem_rsp)
    );

    wb_mem_model u_mem (.rst(rst), .rst_n(rst_n), .mem_req(mem_req), .mem_rsp(mem_rsp));

    initial begin
        rst = 1'b0;
        forever #2 rst = ~rst;                            // 4 ns period
    end

    always @(posedge rst) begin
        if (mem_req.cyc && mem_req.stb && mem_rsp.ack === 1'b1) begin
            beat_q.push_back(mem_req);                    // pre-edge values
        end
    end

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input icache_pkg::word_t exp,
                              input icache_pkg::word_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_req(input string name, input wb_pkg::wb_req_t exp,
                             input wb_pkg::wb_req_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    function automatic icache_pkg::word_t expected_word(input icache_pkg::addr_t a);
        return {a[31:2], 2'b00} ^ 32'h5a5a_0000;          // byte offset ignored
    endfunction

    // one cpu read, returns data, memory beats and ack latency
    task automatic fetch(input icache_pkg::addr_t addr, output icache_pkg::word_t data,
                         output int beats, output int lat);
        int cycles;
        @(posedge rst);
        cpu_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: addr};
        beat_q.delete();
        for (cycles = 0; cycles < FETCH_TIMEOUT; cycles++) begin
            @(posedge rst);                               // first pass samples stb
            if (cpu_rsp.ack === 1'b1) break;
        end
        if (cycles == FETCH_TIMEOUT) begin
            $display("timeout: no cpu ack for address %h at %0t", addr, $time);
            abort_run();
        end
        data    = cpu_rsp.dat;
        beats   = beat_q.size();
        lat     = cycles;
        cpu_req <= '0;                                    // drop stb after ack
    endtask

    task automatic fetch_and_check(input icache_pkg::addr_t addr, input int exp_beats);
        icache_pkg::word_t data;
        icache_pkg::addr_t base;
        int                beats;
        int                lat;
        fetch(addr, data, beats, lat);
        check_word("cpu_rsp.dat", expected_word(addr), data);
        check_count("memory beats", exp_beats, beats);
        base = {addr[31:4], 4'h0};                        // line base
        if (exp_beats == 0) begin
            check_count("hit ack latency", 2, lat);
        end else begin
            for (int i = 0; i < beats; i++) begin
                check_req("mem_req", '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: base + 4 * i},
                          beat_q[i]);
            end
        end
    endtask

    task automatic flush_pulse();
        @(posedge rst);
        flush <= 1'b1;
        @(posedge rst);
        flush <= 1'b0;
    endtask

    task automatic check_after_reset();
        wb_pkg::wb_req_t act;
        act     = mem_req;
        act.adr = '0;                                     // address is don't care when idle
        check_word("cpu_rsp.ack", '0, icache_pkg::word_t'(cpu_rsp.ack));
        check_req("mem_req", '0, act);
    endtask

    task automatic random_fetches();
        icache_pkg::addr_t  a;
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0]   tg;
        int                 exp_beats;
        flush_pulse();
        model_valid = '0;                                 // cache and model both empty
        for (int n = 0; n < 200; n++) begin
            a         = $random(seed) & 32'h0000_3f0c;    // 16 indices, 4 tags
            idx       = a[icache_pkg::LINE_ADDR_LSB +: INDEX_W];
            tg        = a[31 -: TAG_W];
            exp_beats = (model_valid[idx] && model_tag[idx] == tg) ? 0 : 4;
            fetch_and_check(a, exp_beats);
            model_valid[idx] = 1'b1;
            model_tag[idx]   = tg;
        end
    endtask

    initial begin
        rst_n   = 1'b0;
        flush   = 1'b0;
        cpu_req = '0;
        repeat (2) @(posedge rst);
        rst_n <= 1'b1;
        check_after_reset();
        fetch_and_check(32'h0000_1234, 4);                // cold miss
        fetch_and_check(32'h0000_1238, 0);                // same line
        fetch_and_check(32'h0000_2234, 4);                // same index, new tag
        fetch_and_check(32'h0000_1234, 4);                // evicted
        flush_pulse();
        fetch_and_check(32'h0000_1234, 4);
        random_fetches();
        $display("Regression passed");
        $finish;
    end

endmodule

// File: all.f
hdl/icache_pkg.sv
hdl/wb_pkg.sv
hdl/icache_arrays.sv
hdl/icache_ctrl.sv
hdl/icache_refill.sv
hdl/icache_top.sv
sim/wb_mem_model.sv
sim/tb_icache.sv

// File: run.sh
#!/bin/sh
# build and run the icache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_icache

out=$(./obj_dir/Vtb_icache 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Regression passed"; then
    exit 0
else
    exit 1
fi
